//--- rtl/xbus_pkg.sv
// xbus package with the address map, timing constants and the shared bus types
`default_nettype none

package xbus_pkg;

   localparam int ADDR_BITS = 22;
   localparam int DATA_BITS = 32;

   // address map, main memory sits below MAX_ADDR
   localparam logic [ADDR_BITS-1:0] MAX_ADDR = 22'o1100_0000;
   localparam int DRAM_WORDS = 4096;
   localparam int DRAM_BITS  = 12;

   // i/o window, four scratch words then the id word
   localparam logic [ADDR_BITS-1:0] IO_BASE = 22'o1777_7740;
   localparam int IO_WORDS = 5;
   localparam logic [DATA_BITS-1:0] IO_ID = 32'h5a17_0c01;

   // sdram model timing in clock cycles
   localparam int SDRAM_LATENCY    = 3;
   localparam int REFRESH_INTERVAL = 64;
   localparam int REFRESH_CYCLES   = 6;

   // cycles the bus unit waits before flagging nxm
   localparam int BUS_TIMEOUT = 32;

   // counter widths, refresh is the longer controller phase
   localparam int REFRESH_BITS = $clog2(REFRESH_INTERVAL);
   localparam int PHASE_BITS   = $clog2(REFRESH_CYCLES);
   localparam int TIMEOUT_BITS = $clog2(BUS_TIMEOUT);

   typedef enum logic {
      XBUS_READ,
      XBUS_WRITE
   } xbus_op_e;

   typedef struct packed {
      logic [ADDR_BITS-1:0] addr;
      logic [DATA_BITS-1:0] data;
      xbus_op_e             op;
   } xbus_req_t;

   typedef enum logic [1:0] {
      SD_IDLE,
      SD_REFRESH,
      SD_ACCESS,
      SD_DONE
   } sdram_state_e;

   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_WAIT,
      BUS_ACK,
      BUS_RELEASE
   } bus_state_e;

endpackage

`default_nettype wire

//--- rtl/xbus_ram.sv
// xbus main-memory slave, decodes memory space and hands accesses to the sdram controller
`timescale 1ns/1ps
`default_nettype none

module xbus_ram
   import xbus_pkg::*;
(
   // xbus slave side
   input  wire xbus_req_t        request,
   input  wire                   req,
   output logic                  decode,
   output logic                  ack,
   output logic [DATA_BITS-1:0]  dataout,

   // sdram controller side
   output xbus_req_t             sdram_cmd,
   output logic                  sdram_req,
   output logic                  sdram_write,
   input  wire  [DATA_BITS-1:0]  sdram_data,
   input  wire                   sdram_ready,
   input  wire                   sdram_done
);

   logic is_write;

   // everything below MAX_ADDR belongs to memory space,
   // including the part beyond the physical array
   assign decode = (request.addr < MAX_ADDR);

   assign is_write = (request.op == XBUS_WRITE);

   // request split into read and write levels
   assign sdram_req   = req & decode & ~is_write;
   assign sdram_write = req & decode & is_write;

   // address and write data go straight through
   assign sdram_cmd = request;

   // controller answer qualified by the matching level
   assign ack = (sdram_write & sdram_done) | (sdram_req & sdram_ready);

   assign dataout = sdram_data;

endmodule

`default_nettype wire

//--- rtl/sdram_ctrl.sv
// sdram controller model, word array behind a fixed access latency and periodic refresh
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl
   import xbus_pkg::*;
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire xbus_req_t        sdram_cmd,
   input  wire                   sdram_req,
   input  wire                   sdram_write,
   output logic [DATA_BITS-1:0]  sdram_data,
   output logic                  sdram_ready,
   output logic                  sdram_done
);

   sdram_state_e state;

   logic [DATA_BITS-1:0]    mem [DRAM_WORDS];
   // set once a word has been written, unwritten words read zero
   logic [DRAM_WORDS-1:0]   valid;

   logic [REFRESH_BITS-1:0] refresh_cnt;
   logic                    refresh_due;
   logic [PHASE_BITS-1:0]   phase_cnt;
   logic                    is_write;

   logic [DRAM_BITS-1:0]    index;
   logic                    in_range;
   logic                    access_end;
   logic                    refresh_end;

   assign index    = sdram_cmd.addr[DRAM_BITS-1:0];
   assign in_range = (sdram_cmd.addr[ADDR_BITS-1:DRAM_BITS] == '0);

   // last cycle of the access, ready or done rises on the next edge
   assign access_end  = (state == SD_ACCESS) &&
                        (phase_cnt == PHASE_BITS'(SDRAM_LATENCY - 2));
   assign refresh_end = (state == SD_REFRESH) &&
                        (phase_cnt == PHASE_BITS'(REFRESH_CYCLES - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= SD_IDLE;
         refresh_cnt <= '0;
         refresh_due <= 1'b0;
         phase_cnt   <= '0;
         is_write    <= 1'b0;
         sdram_ready <= 1'b0;
         sdram_done  <= 1'b0;
         valid       <= '0;
      end else begin
         refresh_cnt <= refresh_cnt + 1'b1;
         case (state)
            SD_IDLE: begin
               phase_cnt <= '0;
               // pending refresh wins over a new access
               if (refresh_due) begin
                  state       <= SD_REFRESH;
                  refresh_due <= 1'b0;
               end else if (sdram_req | sdram_write) begin
                  state    <= SD_ACCESS;
                  is_write <= (sdram_cmd.op == XBUS_WRITE);
               end
            end
            SD_REFRESH: begin
               phase_cnt <= phase_cnt + 1'b1;
               if (refresh_end) begin
                  state <= SD_IDLE;
               end
            end
            SD_ACCESS: begin
               phase_cnt <= phase_cnt + 1'b1;
               if (access_end) begin
                  state       <= SD_DONE;
                  sdram_ready <= ~is_write;
                  sdram_done  <= is_write;
                  if (is_write && in_range) begin
                     valid[index] <= 1'b1;
                  end
               end
            end
            SD_DONE: begin
               // answer held until the request level drops
               if (!(sdram_req | sdram_write)) begin
                  state       <= SD_IDLE;
                  sdram_ready <= 1'b0;
                  sdram_done  <= 1'b0;
               end
            end
            default: state <= SD_IDLE;
         endcase
         // counter wrap flags a refresh, kept after the case so it is never lost
         if (refresh_cnt == REFRESH_BITS'(REFRESH_INTERVAL - 1)) begin
            refresh_due <= 1'b1;
         end
      end
   end

   // array write and read data, out of range words read all ones
   always_ff @(posedge clk) begin
      if (access_end) begin
         if (is_write) begin
            if (in_range) begin
               mem[index] <= sdram_cmd.data;
            end
         end else if (!in_range) begin
            sdram_data <= '1;
         end else begin
            sdram_data <= valid[index] ? mem[index] : '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/xbus_io.sv
// xbus i/o slave with four scratch registers and a read-only identification word
`timescale 1ns/1ps
`default_nettype none

module xbus_io
   import xbus_pkg::*;
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire xbus_req_t        request,
   input  wire                   req,
   output logic                  decode,
   output logic                  ack,
   output logic [DATA_BITS-1:0]  dataout
);

   logic [DATA_BITS-1:0] scratch [IO_WORDS-1];

   logic [ADDR_BITS-1:0] io_offset;
   logic                 is_id;
   logic                 start;

   // addresses below IO_BASE wrap to large offsets and fail the compare
   assign io_offset = request.addr - IO_BASE;
   assign decode    = (io_offset < ADDR_BITS'(IO_WORDS));

   // id word sits at the top of the window
   assign is_id = (io_offset == ADDR_BITS'(IO_WORDS - 1));

   // first cycle of a decoded request
   assign start = req & decode & ~ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= req & decode;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < IO_WORDS - 1; i++) begin
            scratch[i] <= '0;
         end
      end else if (start && request.op == XBUS_WRITE && !is_id) begin
         scratch[io_offset[1:0]] <= request.data;
      end
   end

   // read data latched with the ack
   always_ff @(posedge clk) begin
      if (start) begin
         if (is_id) begin
            dataout <= IO_ID;
         end else begin
            dataout <= scratch[io_offset[1:0]];
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/xbus_bus.sv
// xbus bus unit, selects the responding slave and times out accesses nobody answers
`timescale 1ns/1ps
`default_nettype none

module xbus_bus
   import xbus_pkg::*;
(
   input  wire                   clk,
   input  wire                   reset,

   // master side
   input  wire                   req,
   output logic [DATA_BITS-1:0]  dataout,
   output logic                  ack,
   output logic                  nxm,

   // slave side
   output logic                  slave_req,
   input  wire                   ram_decode,
   input  wire                   ram_ack,
   input  wire  [DATA_BITS-1:0]  ram_data,
   input  wire                   io_decode,
   input  wire                   io_ack,
   input  wire  [DATA_BITS-1:0]  io_data
);

   bus_state_e state;

   logic [TIMEOUT_BITS-1:0] timer;
   logic                    timed_out;
   logic                    slave_ack;
   logic [DATA_BITS-1:0]    slave_data;

   assign slave_req = req;

   // decodes are disjoint, at most one slave answers
   assign slave_ack  = (ram_decode & ram_ack) | (io_decode & io_ack);
   assign slave_data = ram_decode ? ram_data : io_data;

   assign timed_out = (timer == TIMEOUT_BITS'(BUS_TIMEOUT - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= BUS_IDLE;
         timer <= '0;
         ack   <= 1'b0;
         nxm   <= 1'b0;
      end else begin
         case (state)
            BUS_IDLE: begin
               timer <= '0;
               if (req) begin
                  state <= BUS_WAIT;
                  nxm   <= 1'b0;
               end
            end
            BUS_WAIT: begin
               timer <= timer + 1'b1;
               if (slave_ack) begin
                  state <= BUS_ACK;
                  ack   <= 1'b1;
               end else if (timed_out) begin
                  state <= BUS_ACK;
                  ack   <= 1'b1;
                  nxm   <= 1'b1;
               end
            end
            BUS_ACK: begin
               // ack held as long as the master keeps req high
               if (!req) begin
                  if (slave_ack) begin
                     state <= BUS_RELEASE;
                  end else begin
                     state <= BUS_IDLE;
                     ack   <= 1'b0;
                  end
               end
            end
            BUS_RELEASE: begin
               if (!slave_ack) begin
                  state <= BUS_IDLE;
                  ack   <= 1'b0;
               end
            end
            default: state <= BUS_IDLE;
         endcase
      end
   end

   // response captured when the ack goes out
   always_ff @(posedge clk) begin
      if (state == BUS_WAIT) begin
         if (slave_ack) begin
            dataout <= slave_data;
         end else if (timed_out) begin
            dataout <= '1;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/xbus_top.sv
// xbus memory subsystem top, bus unit with memory and i/o slaves and the sdram model
`timescale 1ns/1ps
`default_nettype none

module xbus_top
   import xbus_pkg::*;
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   req,
   input  wire xbus_req_t        request,
   output logic                  ack,
   output logic [DATA_BITS-1:0]  dataout,
   output logic                  nxm
);

   logic                 slave_req;

   logic                 ram_decode;
   logic                 ram_ack;
   logic [DATA_BITS-1:0] ram_data;

   logic                 io_decode;
   logic                 io_ack;
   logic [DATA_BITS-1:0] io_data;

   // memory slave to controller
   xbus_req_t            sdram_cmd;
   logic                 sdram_req;
   logic                 sdram_write;
   logic [DATA_BITS-1:0] sdram_data;
   logic                 sdram_ready;
   logic                 sdram_done;

   xbus_bus xbus_bus_inst (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .dataout    (dataout),
      .ack        (ack),
      .nxm        (nxm),
      .slave_req  (slave_req),
      .ram_decode (ram_decode),
      .ram_ack    (ram_ack),
      .ram_data   (ram_data),
      .io_decode  (io_decode),
      .io_ack     (io_ack),
      .io_data    (io_data)
   );

   // both slaves see the master's request directly
   xbus_ram xbus_ram_inst (
      .request     (request),
      .req         (slave_req),
      .decode      (ram_decode),
      .ack         (ram_ack),
      .dataout     (ram_data),
      .sdram_cmd   (sdram_cmd),
      .sdram_req   (sdram_req),
      .sdram_write (sdram_write),
      .sdram_data  (sdram_data),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done)
   );

   xbus_io xbus_io_inst (
      .clk     (clk),
      .reset   (reset),
      .request (request),
      .req     (slave_req),
      .decode  (io_decode),
      .ack     (io_ack),
      .dataout (io_data)
   );

   sdram_ctrl sdram_ctrl_inst (
      .clk         (clk),
      .reset       (reset),
      .sdram_cmd   (sdram_cmd),
      .sdram_req   (sdram_req),
      .sdram_write (sdram_write),
      .sdram_data  (sdram_data),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done)
   );

endmodule

`default_nettype wire

//--- verification/xbus_checker.sv
// xbus protocol checker for the four-phase handshake and the sdram answer lines
`timescale 1ns/1ps
`default_nettype none

module xbus_checker
   import xbus_pkg::*;
(
   input wire            clk,
   input wire            reset,
   input wire            req,
   input wire xbus_req_t request,
   input wire            ack,
   input wire            sdram_ready,
   input wire            sdram_done
);

   // ack only answers a req seen on the previous edge
   ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req))
      else $error("ack rose while req was low");

   request_stable: assert property (@(posedge clk) disable iff (reset)
      (req && ack) |=> (!req || $stable(request)))
      else $error("request changed while req and ack were high");

   // release order of the handshake
   ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> !$past(req))
      else $error("ack fell before req was dropped");

   // ready answers only a read and done only a write
   sdram_answer_unique: assert property (@(posedge clk) disable iff (reset)
      (sdram_ready || sdram_done) |->
         ((sdram_ready == (request.op == XBUS_READ)) &&
          (sdram_done == (request.op == XBUS_WRITE))))
      else $error("sdram answer does not match the request op");

endmodule

bind xbus_top xbus_checker xbus_checker_inst (
   .clk         (clk),
   .reset       (reset),
   .req         (req),
   .request     (request),
   .ack         (ack),
   .sdram_ready (sdram_ready),
   .sdram_done  (sdram_done)
);

`default_nettype wire

//--- verification/xbus_tb.sv
// xbus testbench, directed and random accesses through the four-phase handshake
`timescale 1ns/1ps
`default_nettype none

module xbus_tb
   import xbus_pkg::*;
();

   localparam int WAIT_LIMIT  = 200;
   localparam int RANDOM_RUNS = 200;

   logic                 clk;
   logic                 reset;
   logic                 req;
   xbus_req_t            request;
   logic                 ack;
   logic [DATA_BITS-1:0] dataout;
   logic                 nxm;

   int     errors;
   int     checks;
   int     timeouts;
   integer seed;

   // mirror of every in-range memory write
   logic [DATA_BITS-1:0] ref_mem [DRAM_WORDS];

   xbus_top xbus_top_inst (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .request (request),
      .ack     (ack),
      .dataout (dataout),
      .nxm     (nxm)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check(input logic [DATA_BITS-1:0] got,
                        input logic [DATA_BITS-1:0] expected, input string msg);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, expected);
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge clk);
   endtask

   // one full four-phase cycle, called and left on a falling edge
   task automatic handshake(input xbus_op_e op, input logic [ADDR_BITS-1:0] addr,
                            input logic [DATA_BITS-1:0] wdata,
                            output logic [DATA_BITS-1:0] rdata, output logic flag);
      int n;
      request.addr = addr;
      request.data = wdata;
      request.op   = op;
      req          = 1'b1;
      n            = 0;
      @(negedge clk);
      while (!ack && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!ack) begin
         timeouts++;
         $display("timeout: ack never rose for the access to address %o", addr);
      end
      rdata = dataout;
      flag  = nxm;
      req   = 1'b0;
      n     = 0;
      @(negedge clk);
      while (ack && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (ack) begin
         timeouts++;
         $display("timeout: ack stayed high after req dropped, address %o", addr);
      end
   endtask

   task automatic bus_write(input logic [ADDR_BITS-1:0] addr,
                            input logic [DATA_BITS-1:0] data, output logic flag);
      logic [DATA_BITS-1:0] unused_data;
      handshake(XBUS_WRITE, addr, data, unused_data, flag);
   endtask

   task automatic bus_read(input logic [ADDR_BITS-1:0] addr,
                           output logic [DATA_BITS-1:0] data, output logic flag);
      handshake(XBUS_READ, addr, '0, data, flag);
   endtask

   // memory-space write, tracked in the reference array when it is physical
   task automatic mem_write(input logic [ADDR_BITS-1:0] addr,
                            input logic [DATA_BITS-1:0] data);
      logic flag;
      bus_write(addr, data, flag);
      check(32'(flag), 0, "nxm on memory write");
      if (addr < ADDR_BITS'(DRAM_WORDS)) begin
         ref_mem[addr[DRAM_BITS-1:0]] = data;
      end
   endtask

   // beyond the physical array memory space reads all ones
   task automatic mem_read(input logic [ADDR_BITS-1:0] addr, input string msg);
      logic [DATA_BITS-1:0] rd;
      logic [DATA_BITS-1:0] expected;
      logic                 flag;
      expected = (addr < ADDR_BITS'(DRAM_WORDS)) ? ref_mem[addr[DRAM_BITS-1:0]] : '1;
      bus_read(addr, rd, flag);
      check(rd, expected, msg);
      check(32'(flag), 0, "nxm on memory read");
   endtask

   task automatic test_reset_state();
      check(32'(ack), 0, "ack after reset");
      check(32'(nxm), 0, "nxm after reset");
      mem_read(22'o123, "unwritten word after reset");
   endtask

   task automatic test_memory();
      mem_write(22'd0, 32'h0123_4567);
      mem_write(22'd1, 32'hdead_beef);
      mem_write(22'd2, 32'h5555_aaaa);
      mem_write(ADDR_BITS'(DRAM_WORDS - 1), 32'hfeed_f00d);
      mem_read(22'd0, "read back word 0");
      mem_read(22'd1, "read back word 1");
      mem_read(22'd2, "read back word 2");
      mem_read(ADDR_BITS'(DRAM_WORDS - 1), "read back last physical word");
   endtask

   task automatic test_beyond_physical();
      mem_write(22'd5, 32'h0000_0505);
      // same low 12 bits as word 5
      mem_write(ADDR_BITS'(DRAM_WORDS + 5), 32'hbad0_0005);
      mem_read(ADDR_BITS'(DRAM_WORDS), "first word past the array");
      mem_read(ADDR_BITS'(DRAM_WORDS + 5), "written word past the array");
      mem_read(MAX_ADDR - 1'b1, "last memory-space word");
      mem_read(22'd5, "aliased physical word unchanged");
   endtask

   task automatic test_io();
      logic [DATA_BITS-1:0] rd;
      logic                 flag;
      for (int i = 0; i < IO_WORDS - 1; i++) begin
         bus_write(IO_BASE + ADDR_BITS'(i), 32'hc0de_0a00 + DATA_BITS'(i), flag);
         check(32'(flag), 0, "nxm on scratch write");
      end
      for (int i = 0; i < IO_WORDS - 1; i++) begin
         bus_read(IO_BASE + ADDR_BITS'(i), rd, flag);
         check(rd, 32'hc0de_0a00 + DATA_BITS'(i), "scratch register read back");
         check(32'(flag), 0, "nxm on scratch read");
      end
      bus_read(IO_BASE + 22'd4, rd, flag);
      check(rd, 32'h5a17_0c01, "id register");
      bus_write(IO_BASE + 22'd4, 32'h0000_0000, flag);
      check(32'(flag), 0, "nxm on id write");
      bus_read(IO_BASE + 22'd4, rd, flag);
      check(rd, 32'h5a17_0c01, "id register after a write");
   endtask

   task automatic test_unmapped();
      logic [DATA_BITS-1:0] rd;
      logic                 flag;
      bus_read(MAX_ADDR, rd, flag);
      check(rd, '1, "data from unmapped read");
      check(32'(flag), 1, "nxm on unmapped read");
      check(32'(nxm), 1, "nxm held after the unmapped access");
      // gap just below the i/o window
      bus_write(IO_BASE - 1'b1, 32'h1234_5678, flag);
      check(32'(flag), 1, "nxm on unmapped write");
      mem_read(22'd1, "valid access after nxm");
      check(32'(nxm), 0, "nxm cleared by a valid access");
   endtask

   // random idle gaps move the accesses across refresh
   task automatic test_random();
      logic [31:0]          rnd;
      logic [DATA_BITS-1:0] wdata;
      logic [ADDR_BITS-1:0] addr;
      for (int i = 0; i < RANDOM_RUNS; i++) begin
         rnd  = $random(seed);
         addr = ADDR_BITS'(rnd[9:0]);
         if (rnd[31]) begin
            wdata = $random(seed);
            mem_write(addr, wdata);
         end else begin
            mem_read(addr, "random read");
         end
         idle(int'(rnd[16:12]));
      end
   endtask

   initial begin
      errors   = 0;
      checks   = 0;
      timeouts = 0;
      seed     = 32'h1f19_d750;
      reset    = 1'b1;
      req      = 1'b0;
      request  = '0;
      for (int i = 0; i < DRAM_WORDS; i++) begin
         ref_mem[DRAM_BITS'(i)] = '0;
      end
      repeat (4) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      test_reset_state();
      test_memory();
      test_beyond_physical();
      test_io();
      test_unmapped();
      test_random();
      idle(4);

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
rtl/xbus_pkg.sv
rtl/xbus_ram.sv
rtl/sdram_ctrl.sv
rtl/xbus_io.sv
rtl/xbus_bus.sv
rtl/xbus_top.sv
verification/xbus_checker.sv
verification/xbus_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the xbus testbench with verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module xbus_tb -f compile.f -o xbus_sim; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/xbus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "sim passed" "$LOG"; then
   echo "result: pass"
   exit 0
else
   echo "result: fail"
   exit 1
fi
